// File: verilog/mag_pkg.sv
// ==========================================================
// Shared types and defaults for the magnitude estimator
// Denominator defaults must stay powers of two
// Default Alpha 1, Beta 1/4 keeps the combine multiplierless
// ==========================================================

`default_nettype none

package mag_pkg;

  // Occupancy of a one-entry stage buffer
  typedef enum logic {
    BUF_EMPTY = 1'b0,
    BUF_FULL  = 1'b1
  } buf_state_e;

  // Width of one I or Q half, also of the magnitude
  localparam int DEF_SAMP_WIDTH = 16;

  // Alpha = 1, Beta = 1/4
  localparam int DEF_ALPHA_NUM   = 1;
  localparam int DEF_ALPHA_DENOM = 1;
  localparam int DEF_BETA_NUM    = 1;
  localparam int DEF_BETA_DENOM  = 4;

endpackage

`default_nettype wire

// File: verilog/axis_flop_stage.sv
// ==========================================================
// One-entry registered stream buffer, full throughput
// i_tready depends combinationally on o_tready
// Payload registers carry no reset, only the state does
// ==========================================================

`default_nettype none

module axis_flop_stage #(
  parameter int WIDTH = mag_pkg::DEF_SAMP_WIDTH
) (
  input  wire              clk,
  input  logic             i_rst,
  input  logic             i_clear,
  input  logic [WIDTH-1:0] i_tdata,
  input  logic             i_tlast,
  input  logic             i_tvalid,
  output logic             i_tready,
  output logic [WIDTH-1:0] o_tdata,
  output logic             o_tlast,
  output logic             o_tvalid,
  input  logic             o_tready
);

  import mag_pkg::*;

  buf_state_e state;
  logic       load;

  // Take new data when empty or when the held entry leaves now
  assign i_tready = (state == BUF_EMPTY) || o_tready;
  assign load     = i_tvalid && i_tready;
  assign o_tvalid = (state == BUF_FULL);

  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      state <= BUF_EMPTY;
    end else if (load) begin
      state <= BUF_FULL;
    end else if (o_tready) begin
      state <= BUF_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      o_tdata <= i_tdata;
      o_tlast <= i_tlast;
    end
  end

  // ==========================================================
  // Stream checks
  // ==========================================================

  // Upstream holds a stalled beat until it is taken
  a_in_valid_hold: assert property (@(posedge clk) disable iff (i_rst || i_clear)
    i_tvalid && !i_tready |=> i_tvalid);

  a_in_data_hold: assert property (@(posedge clk) disable iff (i_rst || i_clear)
    i_tvalid && !i_tready |=> $stable(i_tdata) && $stable(i_tlast));

endmodule

`default_nettype wire

// File: verilog/abs_stage.sv
// ==========================================================
// Stage 1: two's-complement absolute value of I and Q
// I sits in the upper half of i_tdata
// Most negative input maps to 2**(SAMP_WIDTH-1) exactly
// ==========================================================

`default_nettype none

module abs_stage #(
  parameter int SAMP_WIDTH = mag_pkg::DEF_SAMP_WIDTH
) (
  input  wire                     clk,
  input  logic                    i_rst,
  input  logic                    i_clear,
  input  logic [2*SAMP_WIDTH-1:0] i_tdata,
  input  logic                    i_tlast,
  input  logic                    i_tvalid,
  output logic                    i_tready,
  output logic [SAMP_WIDTH-1:0]   o_abs_i,
  output logic [SAMP_WIDTH-1:0]   o_abs_q,
  output logic                    o_tlast,
  output logic                    o_tvalid,
  input  logic                    o_tready
);

  logic [SAMP_WIDTH-1:0]   samp_i;
  logic [SAMP_WIDTH-1:0]   samp_q;
  logic [SAMP_WIDTH-1:0]   abs_i;
  logic [SAMP_WIDTH-1:0]   abs_q;
  logic [2*SAMP_WIDTH-1:0] held;

  assign samp_i = i_tdata[2*SAMP_WIDTH-1:SAMP_WIDTH];
  assign samp_q = i_tdata[SAMP_WIDTH-1:0];

  // Negate on sign bit, result read as unsigned
  assign abs_i = samp_i[SAMP_WIDTH-1] ? (~samp_i + 1'b1) : samp_i;
  assign abs_q = samp_q[SAMP_WIDTH-1] ? (~samp_q + 1'b1) : samp_q;

  axis_flop_stage #(.WIDTH(2*SAMP_WIDTH)) u_flop (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
    .i_tdata({abs_i, abs_q}), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .i_tready(i_tready),
    .o_tdata(held), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .o_tready(o_tready)
  );

  assign o_abs_i = held[2*SAMP_WIDTH-1:SAMP_WIDTH];
  assign o_abs_q = held[SAMP_WIDTH-1:0];

endmodule

`default_nettype wire

// File: verilog/minmax_stage.sv
// ==========================================================
// Stage 2: sort two unsigned magnitudes into max and min
// Single comparator, ties pass equal values on both outputs
// ==========================================================

`default_nettype none

module minmax_stage #(
  parameter int SAMP_WIDTH = mag_pkg::DEF_SAMP_WIDTH
) (
  input  wire                   clk,
  input  logic                  i_rst,
  input  logic                  i_clear,
  input  logic [SAMP_WIDTH-1:0] i_abs_i,
  input  logic [SAMP_WIDTH-1:0] i_abs_q,
  input  logic                  i_tlast,
  input  logic                  i_tvalid,
  output logic                  i_tready,
  output logic [SAMP_WIDTH-1:0] o_max,
  output logic [SAMP_WIDTH-1:0] o_min,
  output logic                  o_tlast,
  output logic                  o_tvalid,
  input  logic                  o_tready
);

  logic                    i_gt_q;
  logic [SAMP_WIDTH-1:0]   max_val;
  logic [SAMP_WIDTH-1:0]   min_val;
  logic [2*SAMP_WIDTH-1:0] held;

  // One compare drives both muxes
  assign i_gt_q  = (i_abs_i > i_abs_q);
  assign max_val = i_gt_q ? i_abs_i : i_abs_q;
  assign min_val = i_gt_q ? i_abs_q : i_abs_i;

  axis_flop_stage #(.WIDTH(2*SAMP_WIDTH)) u_flop (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
    .i_tdata({max_val, min_val}), .i_tlast(i_tlast), .i_tvalid(i_tvalid),
    .i_tready(i_tready),
    .o_tdata(held), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .o_tready(o_tready)
  );

  assign o_max = held[2*SAMP_WIDTH-1:SAMP_WIDTH];
  assign o_min = held[SAMP_WIDTH-1:0];

endmodule

`default_nettype wire

// File: verilog/mag_combine_stage.sv
// ==========================================================
// Stage 3: mag = Alpha * max + Beta * min, saturating
// Alpha = ALPHA_NUM / ALPHA_DENOM, Beta likewise
// Denominators must be powers of two, checked at elaboration
// Bits shifted out below the denominator are dropped
// Overflow clamps to all ones instead of wrapping
// ==========================================================

`default_nettype none

module mag_combine_stage #(
  parameter int SAMP_WIDTH  = mag_pkg::DEF_SAMP_WIDTH,
  parameter int ALPHA_NUM   = mag_pkg::DEF_ALPHA_NUM,
  parameter int ALPHA_DENOM = mag_pkg::DEF_ALPHA_DENOM,
  parameter int BETA_NUM    = mag_pkg::DEF_BETA_NUM,
  parameter int BETA_DENOM  = mag_pkg::DEF_BETA_DENOM
) (
  input  wire                   clk,
  input  logic                  i_rst,
  input  logic                  i_clear,
  input  logic [SAMP_WIDTH-1:0] i_max,
  input  logic [SAMP_WIDTH-1:0] i_min,
  input  logic                  i_tlast,
  input  logic                  i_tvalid,
  output logic                  i_tready,
  output logic [SAMP_WIDTH-1:0] o_mag,
  output logic                  o_tlast,
  output logic                  o_tvalid,
  input  logic                  o_tready
);

  localparam int ALPHA_SHIFT = $clog2(ALPHA_DENOM);
  localparam int BETA_SHIFT  = $clog2(BETA_DENOM);
  localparam int ALPHA_BITS  = $clog2(ALPHA_NUM + 1);
  localparam int BETA_BITS   = $clog2(BETA_NUM + 1);
  localparam int NUM_BITS    = (ALPHA_BITS > BETA_BITS) ? ALPHA_BITS : BETA_BITS;
  // Room for the larger numerator plus the carry of the add
  localparam int SUM_WIDTH   = SAMP_WIDTH + NUM_BITS + 1;

  if ((ALPHA_DENOM < 1) || ((ALPHA_DENOM & (ALPHA_DENOM - 1)) != 0)) begin : g_bad_alpha
    $error("ALPHA_DENOM must be a power of two");
  end
  if ((BETA_DENOM < 1) || ((BETA_DENOM & (BETA_DENOM - 1)) != 0)) begin : g_bad_beta
    $error("BETA_DENOM must be a power of two");
  end

  logic [SUM_WIDTH-1:0]  alpha_term;
  logic [SUM_WIDTH-1:0]  beta_term;
  logic [SUM_WIDTH-1:0]  sum;
  logic [SAMP_WIDTH-1:0] mag;

  // Shift first, then scale; numerator of 1 leaves no multiplier
  assign alpha_term = SUM_WIDTH'(ALPHA_NUM) * SUM_WIDTH'(i_max >> ALPHA_SHIFT);
  assign beta_term  = SUM_WIDTH'(BETA_NUM) * SUM_WIDTH'(i_min >> BETA_SHIFT);
  assign sum        = alpha_term + beta_term;

  // Anything above the output width means clamp
  assign mag = (|sum[SUM_WIDTH-1:SAMP_WIDTH]) ? '1 : sum[SAMP_WIDTH-1:0];

  axis_flop_stage #(.WIDTH(SAMP_WIDTH)) u_flop (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
    .i_tdata(mag), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .i_tready(i_tready),
    .o_tdata(o_mag), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .o_tready(o_tready)
  );

endmodule

`default_nettype wire

// File: verilog/mag_approx_top.sv
// ==========================================================
// Alpha-max-plus-beta-min magnitude estimator, streaming
// Input word is {I, Q}, both signed; output is unsigned
// Fixed latency of 3 cycles, one sample per cycle
// i_clear drops every sample in flight
// ==========================================================

`default_nettype none

module mag_approx_top #(
  parameter int SAMP_WIDTH  = mag_pkg::DEF_SAMP_WIDTH,
  parameter int ALPHA_NUM   = mag_pkg::DEF_ALPHA_NUM,
  parameter int ALPHA_DENOM = mag_pkg::DEF_ALPHA_DENOM,
  parameter int BETA_NUM    = mag_pkg::DEF_BETA_NUM,
  parameter int BETA_DENOM  = mag_pkg::DEF_BETA_DENOM
) (
  input  wire                     clk,
  input  logic                    i_rst,
  input  logic                    i_clear,
  input  logic [2*SAMP_WIDTH-1:0] i_tdata,
  input  logic                    i_tlast,
  input  logic                    i_tvalid,
  output logic                    i_tready,
  output logic [SAMP_WIDTH-1:0]   o_tdata,
  output logic                    o_tlast,
  output logic                    o_tvalid,
  input  logic                    o_tready
);

  // Stage 1 to stage 2
  logic [SAMP_WIDTH-1:0] abs_i;
  logic [SAMP_WIDTH-1:0] abs_q;
  logic                  abs_last;
  logic                  abs_valid;
  logic                  abs_ready;

  // Stage 2 to stage 3
  logic [SAMP_WIDTH-1:0] mm_max;
  logic [SAMP_WIDTH-1:0] mm_min;
  logic                  mm_last;
  logic                  mm_valid;
  logic                  mm_ready;

  abs_stage #(.SAMP_WIDTH(SAMP_WIDTH)) u_abs (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .i_tready(i_tready),
    .o_abs_i(abs_i), .o_abs_q(abs_q), .o_tlast(abs_last), .o_tvalid(abs_valid),
    .o_tready(abs_ready)
  );

  minmax_stage #(.SAMP_WIDTH(SAMP_WIDTH)) u_minmax (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
    .i_abs_i(abs_i), .i_abs_q(abs_q), .i_tlast(abs_last), .i_tvalid(abs_valid),
    .i_tready(abs_ready),
    .o_max(mm_max), .o_min(mm_min), .o_tlast(mm_last), .o_tvalid(mm_valid),
    .o_tready(mm_ready)
  );

  mag_combine_stage #(
    .SAMP_WIDTH(SAMP_WIDTH), .ALPHA_NUM(ALPHA_NUM), .ALPHA_DENOM(ALPHA_DENOM),
    .BETA_NUM(BETA_NUM), .BETA_DENOM(BETA_DENOM)
  ) u_combine (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
    .i_max(mm_max), .i_min(mm_min), .i_tlast(mm_last), .i_tvalid(mm_valid),
    .i_tready(mm_ready),
    .o_mag(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .o_tready(o_tready)
  );

endmodule

`default_nettype wire

// File: tb/mag_approx_vectors.svh
// ============================================================
// Stimulus table for the magnitude estimator testbench
// Columns: name, I, Q, last, magnitude at Alpha 1 Beta 1/4,
// magnitude at Alpha 2 Beta 1/4 clamped to 65535
// Expected values are max + min/4 and 2*max + min/4, with the
// min bits below the shift dropped
// ============================================================

`ifndef MAG_APPROX_VECTORS_SVH
`define MAG_APPROX_VECTORS_SVH

task automatic load_vectors();
  // Every sign and order of the pair (3000, 1000)
  add_vector("sign_pp",   16'sd3000,  16'sd1000,  1'b0, 16'd3250,  16'd6250);
  add_vector("sign_np",  -16'sd3000,  16'sd1000,  1'b0, 16'd3250,  16'd6250);
  add_vector("sign_pn",   16'sd3000, -16'sd1000,  1'b0, 16'd3250,  16'd6250);
  add_vector("sign_nn",  -16'sd3000, -16'sd1000,  1'b1, 16'd3250,  16'd6250);
  add_vector("swap_pp",   16'sd1000,  16'sd3000,  1'b0, 16'd3250,  16'd6250);
  add_vector("swap_np",  -16'sd1000,  16'sd3000,  1'b0, 16'd3250,  16'd6250);
  add_vector("swap_pn",   16'sd1000, -16'sd3000,  1'b0, 16'd3250,  16'd6250);
  add_vector("swap_nn",  -16'sd1000, -16'sd3000,  1'b1, 16'd3250,  16'd6250);
  // Most negative half maps to 32768
  add_vector("minneg_i",  16'h8000,   16'sd0,     1'b0, 16'd32768, 16'd65535);
  add_vector("minneg_q",  16'sd0,     16'h8000,   1'b0, 16'd32768, 16'd65535);
  add_vector("minneg_iq", 16'h8000,   16'sd100,   1'b0, 16'd32793, 16'd65535);
  add_vector("minneg_qi", 16'sd100,   16'h8000,   1'b1, 16'd32793, 16'd65535);
  // Exact scaled sums
  add_vector("scale",     16'sd1000,  16'sd400,   1'b0, 16'd1100,  16'd2100);
  add_vector("scale_swp",-16'sd400,   16'sd1000,  1'b0, 16'd1100,  16'd2100);
  add_vector("drop_bits", 16'sd1003,  16'sd7,     1'b0, 16'd1004,  16'd2007);
  add_vector("tiny",      16'sd5,     16'sd3,     1'b0, 16'd5,     16'd10);
  add_vector("zero",      16'sd0,     16'sd0,     1'b0, 16'd0,     16'd0);
  add_vector("tie",       16'sd12,   -16'sd12,    1'b1, 16'd15,    16'd27);
  // Around the clamp of the Alpha 2 instance
  add_vector("below_sat", 16'sd32000, 16'sd6136,  1'b0, 16'd33534, 16'd65534);
  add_vector("over_sat",  16'sd32000, 16'sd6144,  1'b0, 16'd33536, 16'd65535);
  add_vector("max_pos",   16'sd32767, 16'sd32767, 1'b0, 16'd40958, 16'd65535);
  add_vector("full_neg",  16'h8000,   16'h8000,   1'b1, 16'd40960, 16'd65535);
endtask

`endif

// File: tb/mag_approx_tb.sv
// ============================================================
// Testbench for mag_approx_top, default Alpha 1 and Beta 1/4
// A second instance with Alpha 2 reaches the output clamp
// Inputs change on the falling edge, handshakes read on rising
// ============================================================

`default_nettype none

module mag_approx_tb;

  import mag_pkg::*;

  localparam int W    = DEF_SAMP_WIDTH;
  localparam int SEED = 32'h70f4b5ff;

  logic           clk;
  logic           i_rst;
  logic           i_clear;
  logic [2*W-1:0] i_tdata;
  logic           i_tlast;
  logic           i_tvalid;
  logic           dut_tready;
  logic [W-1:0]   o_tdata;
  logic           o_tlast;
  logic           o_tvalid;
  logic           o_tready;
  logic           sat_tready;
  logic [W-1:0]   sat_tdata;
  logic           sat_tlast;
  logic           sat_tvalid;

  string        vec_name[$];
  logic [W-1:0] vec_i[$];
  logic [W-1:0] vec_q[$];
  logic         vec_last[$];
  logic [W-1:0] vec_mag[$];
  logic [W-1:0] vec_sat[$];
  int           cycle_count;
  int           sent;
  int           received;
  int           gap;
  int           latency;
  int           extra;
  bit           pending;

  mag_approx_top #(
    .SAMP_WIDTH(W), .ALPHA_NUM(DEF_ALPHA_NUM), .ALPHA_DENOM(DEF_ALPHA_DENOM),
    .BETA_NUM(DEF_BETA_NUM), .BETA_DENOM(DEF_BETA_DENOM)
  ) dut0 (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear), .i_tdata(i_tdata), .i_tlast(i_tlast),
    .i_tvalid(i_tvalid), .i_tready(dut_tready), .o_tdata(o_tdata), .o_tlast(o_tlast),
    .o_tvalid(o_tvalid), .o_tready(o_tready)
  );

  // Same stream, Alpha 2, runs in lockstep with dut0
  mag_approx_top #(
    .SAMP_WIDTH(W), .ALPHA_NUM(2), .ALPHA_DENOM(DEF_ALPHA_DENOM),
    .BETA_NUM(DEF_BETA_NUM), .BETA_DENOM(DEF_BETA_DENOM)
  ) dut_sat (
    .clk(clk), .i_rst(i_rst), .i_clear(i_clear), .i_tdata(i_tdata), .i_tlast(i_tlast),
    .i_tvalid(i_tvalid), .i_tready(sat_tready), .o_tdata(sat_tdata), .o_tlast(sat_tlast),
    .o_tvalid(sat_tvalid), .o_tready(o_tready)
  );

  task automatic add_vector(input string name, input logic [W-1:0] samp_i,
                            input logic [W-1:0] samp_q, input logic last,
                            input logic [W-1:0] mag, input logic [W-1:0] sat_mag);
    vec_name.push_back(name);
    vec_i.push_back(samp_i);
    vec_q.push_back(samp_q);
    vec_last.push_back(last);
    vec_mag.push_back(mag);
    vec_sat.push_back(sat_mag);
  endtask

  `include "mag_approx_vectors.svh"

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_mag(input string name, input logic [W-1:0] expected,
                           input logic [W-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s magnitude expected %0d actual %0d",
                          name, expected, actual));
    end
  endtask

  task automatic check_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s last expected %0b actual %0b", name, expected, actual));
    end
  endtask

  // Both instances must present table entry idx together
  task automatic check_output(input int idx);
    check_mag(vec_name[idx], vec_mag[idx], o_tdata);
    check_last(vec_name[idx], vec_last[idx], o_tlast);
    if (sat_tvalid !== 1'b1) begin
      abort_run("the Alpha 2 instance fell out of step with dut0");
    end
    check_mag({vec_name[idx], "_alpha2"}, vec_sat[idx], sat_tdata);
    check_last({vec_name[idx], "_alpha2"}, vec_last[idx], sat_tlast);
  endtask

  task automatic drive_sample(input int idx);
    i_tdata  = {vec_i[idx], vec_q[idx]};
    i_tlast  = vec_last[idx];
    i_tvalid = 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > 4 * vec_name.size() + 50) begin
        abort_run("timeout: the run did not finish within the cycle limit");
      end
    end
  end

  initial begin
    i_rst    = 1'b1;
    i_clear  = 1'b0;
    i_tdata  = '0;
    i_tlast  = 1'b0;
    i_tvalid = 1'b0;
    o_tready = 1'b0;
    void'($urandom(SEED));
    load_vectors();
    repeat (4) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;
    if (o_tvalid !== 1'b0 || dut_tready !== 1'b1) begin
      abort_run("after reset o_tvalid is not low or i_tready is not high");
    end

    // ============================================================
    // One isolated sample, output ready held high
    // ============================================================
    o_tready = 1'b1;
    drive_sample(0);
    @(posedge clk);
    @(negedge clk);
    i_tvalid = 1'b0;
    latency = 1;
    while (!o_tvalid && latency < 10) begin
      @(negedge clk);
      latency++;
    end
    if (latency != 3) begin
      abort_run($sformatf("error: latency expected 3 actual %0d", latency));
    end
    check_output(0);
    @(negedge clk);

    // ============================================================
    // Two samples in flight, then i_clear
    // ============================================================
    o_tready = 1'b0;
    drive_sample(1);
    @(negedge clk);
    drive_sample(2);
    @(negedge clk);
    i_tvalid = 1'b0;
    i_clear  = 1'b1;
    @(negedge clk);
    i_clear  = 1'b0;
    o_tready = 1'b1;
    repeat (5) begin
      if (o_tvalid !== 1'b0 || dut_tready !== 1'b1) begin
        abort_run("a sample survived i_clear or the input is not ready");
      end
      @(negedge clk);
    end

    // ============================================================
    // Whole table with idle gaps and random output ready
    // ============================================================
    sent     = 0;
    received = 0;
    gap      = 0;
    pending  = 1'b0;
    while (received < vec_name.size()) begin
      @(negedge clk);
      o_tready = ($urandom_range(0, 3) != 0);
      if (!pending) begin
        i_tvalid = 1'b0;
        if (gap > 0) begin
          gap--;
        end else if (sent < vec_name.size()) begin
          drive_sample(sent);
          pending = 1'b1;
        end
      end
      @(posedge clk);
      if (sat_tready !== dut_tready || sat_tvalid !== o_tvalid) begin
        abort_run("the Alpha 2 instance handshake differs from dut0");
      end
      if (i_tvalid && dut_tready) begin
        sent++;
        pending = 1'b0;
        gap     = $urandom_range(0, 2);
      end
      if (o_tvalid && o_tready) begin
        check_output(received);
        received++;
      end
    end

    // Nothing may follow the last table entry
    extra = 0;
    repeat (4) begin
      @(negedge clk);
      i_tvalid = 1'b0;
      o_tready = 1'b1;
      if (o_tvalid) begin
        extra++;
      end
    end
    if (extra == 0 && sent == vec_name.size()) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run("extra output samples appeared after the last table entry");
    end
  end

endmodule

`default_nettype wire

// File: mag_approx.f
+incdir+tb
verilog/mag_pkg.sv
verilog/axis_flop_stage.sv
verilog/abs_stage.sv
verilog/minmax_stage.sv
verilog/mag_combine_stage.sv
verilog/mag_approx_top.sv
tb/mag_approx_tb.sv

// File: Makefile
# Verilator build and run for the magnitude estimator
VERILATOR ?= verilator
SIM_TOP   ?= mag_approx_tb
FILELIST  ?= mag_approx.f
BUILD_DIR ?= ./obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR SIM_TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(SIM_TOP)
	-$(BUILD_DIR)/V$(SIM_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "TEST PASSED" || (echo "TEST FAILED"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
